/* bender.yml */
package:
  name: wbf

export_include_dirs:
  - src

sources:
  - files:
      - src/wbf_pkg.sv
      - src/wbf_fifo.sv
      - src/wbf_regs.sv
      - src/wbf_port.sv
      - src/wbf_top.sv
  - target: simulation
    files:
      - sim/wbf_props.sv
      - sim/wbf_tb.sv

/* src.f */
+incdir+src
src/wbf_pkg.sv
src/wbf_fifo.sv
src/wbf_regs.sv
src/wbf_port.sv
src/wbf_top.sv
sim/wbf_props.sv
sim/wbf_tb.sv

/* sim/wbf_tb.sv */
`include "wbf_cfg.svh"

module wbf_tb;

	import wbf_pkg::*;

	localparam int ACK_LIMIT   = 16;
	localparam int DRAIN_LIMIT = 16;

	logic       wb_clk_i;
	logic       reset_i;
	adr_t       wb_adr_i;
	word_t      wb_dat_i;
	sel_t       wb_sel_i;
	logic       wb_we_i;
	logic       wb_cyc_i;
	logic       wb_stb_i;
	word_t      wb_dat_o;
	logic       wb_ack_o;
	logic       irq_o;
	word_t      fifo_s2m_dat_i;
	logic       fifo_s2m_we_i;
	logic       fifo_s2m_empty_o;
	logic       fifo_s2m_full_o;
	word_t      fifo_m2s_dat_o;
	sel_t       fifo_m2s_sel_o;
	logic       fifo_m2s_valid_o;
	logic       fifo_m2s_re_i;
	logic       fifo_m2s_empty_o;
	logic       fifo_m2s_full_o;

	// Reference state
	m2s_entry_t ref_m2s[$];
	word_t      ref_s2m[$];
	drop_cnt_t  ref_drops = '0;
	m2s_entry_t exp_pops[$];   // Entries the outside port still owes

	wbf_top DUT (.*);

	initial begin
		wb_clk_i = 1'b0;
		forever #4 wb_clk_i = ~wb_clk_i;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_status(input string name, input status_t expected,
			input status_t actual);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected %b got %b", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_entry(input string name, input m2s_entry_t expected,
			input m2s_entry_t actual);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input drop_cnt_t expected,
			input drop_cnt_t actual);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic status_t model_status();
		status_t st;
		st.s2m_empty = (ref_s2m.size() == 0);
		st.s2m_full  = (ref_s2m.size() == `WBF_DEPTH);
		st.m2s_empty = (ref_m2s.size() == 0);
		st.m2s_full  = (ref_m2s.size() == `WBF_DEPTH);
		st.irq       = (ref_s2m.size() != 0);
		return st;
	endfunction

	// One clock cycle of traffic and its expected bus read word
	function automatic word_t model_step(input logic bus_en, input logic we, input adr_t adr,
			input word_t dat, input sel_t sel, input logic s_we, input word_t s_dat,
			input logic m_re);
		word_t rd;
		logic  hit;
		logic  push_m;
		logic  pop_m;
		logic  push_s;
		logic  pop_s;
		rd  = '0;
		hit = bus_en && (adr == adr_t'(`WBF_ADR_DATA));
		// Every decision sees the queues as they were before the edge
		push_m = hit && we && (ref_m2s.size() < `WBF_DEPTH);
		pop_s  = hit && !we && (ref_s2m.size() > 0);
		pop_m  = m_re && (ref_m2s.size() > 0);
		push_s = s_we && (ref_s2m.size() < `WBF_DEPTH);
		if (bus_en && !we) begin
			case (adr)
				adr_t'(`WBF_ADR_DATA):   rd = pop_s ? ref_s2m[0] : '0;
				adr_t'(`WBF_ADR_STATUS): rd = word_t'(model_status());
				adr_t'(`WBF_ADR_DROPS):  rd = word_t'(ref_drops);
				default:                 rd = '0;
			endcase
		end
		if (pop_m)
			exp_pops.push_back(ref_m2s.pop_front());
		if (push_m)
			ref_m2s.push_back(m2s_entry_t'{data: dat, sel: sel});
		if (pop_s)
			void'(ref_s2m.pop_front());
		if (push_s)
			ref_s2m.push_back(s_dat);
		else if (s_we && ref_drops != 8'hff)   // Counter saturates
			ref_drops = ref_drops + 8'd1;
		return rd;
	endfunction

	////////////////////////////////////////////////////////////
	// Drivers entered 1 unit after a rising edge

	task automatic check_flags();
		check_status("status flags", model_status(), status_t'({irq_o, fifo_m2s_full_o,
			fifo_m2s_empty_o, fifo_s2m_full_o, fifo_s2m_empty_o}));
	endtask

	task automatic agent_cycle(input logic s_we, input word_t s_dat, input logic m_re);
		fifo_s2m_we_i  = s_we;
		fifo_s2m_dat_i = s_dat;
		fifo_m2s_re_i  = m_re;
		void'(model_step(1'b0, 1'b0, '0, '0, '0, s_we, s_dat, m_re));
		@(posedge wb_clk_i);
		#1;
		fifo_s2m_we_i = 1'b0;
		fifo_m2s_re_i = 1'b0;
		check_flags();
	endtask

	// Bus access with optional outside traffic in the request cycle
	task automatic bus_access(input logic we, input adr_t adr, input word_t dat,
			input sel_t sel, input logic s_we, input word_t s_dat, input logic m_re);
		word_t expected;
		int    n;
		wb_we_i        = we;
		wb_adr_i       = adr;
		wb_dat_i       = dat;
		wb_sel_i       = sel;
		wb_cyc_i       = 1'b1;
		wb_stb_i       = 1'b1;
		fifo_s2m_we_i  = s_we;
		fifo_s2m_dat_i = s_dat;
		fifo_m2s_re_i  = m_re;
		expected = model_step(1'b1, we, adr, dat, sel, s_we, s_dat, m_re);
		n = 0;
		do begin
			@(posedge wb_clk_i);
			#1;
			fifo_s2m_we_i = 1'b0;
			fifo_m2s_re_i = 1'b0;
			n++;
		end while (!wb_ack_o && n < ACK_LIMIT);
		if (!wb_ack_o) begin
			$display("Timeout: no bus ack within %0d cycles at time %0t", n, $time);
			abort_run();
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		check_flags();
		if (!we) begin
			if (adr == adr_t'(`WBF_ADR_STATUS))
				check_status("wb_dat_o status", status_t'(expected[4:0]),
					status_t'(wb_dat_o[4:0]));
			if (adr == adr_t'(`WBF_ADR_DROPS))
				check_count("wb_dat_o drops", drop_cnt_t'(expected), drop_cnt_t'(wb_dat_o));
			check_word("wb_dat_o", expected, wb_dat_o);
		end
		@(posedge wb_clk_i);   // Idle cycle so the ack drops
		#1;
	endtask

	task automatic bus_write(input adr_t adr, input word_t dat, input sel_t sel);
		bus_access(1'b1, adr, dat, sel, 1'b0, '0, 1'b0);
	endtask

	task automatic bus_read(input adr_t adr);
		bus_access(1'b0, adr, '0, '0, 1'b0, '0, 1'b0);
	endtask

	// Bound assertions and popped entries against the model in order
	always @(negedge wb_clk_i) begin
		if (DUT.u_props.fail_cnt != 0) begin
			$display("Assertion failure in the bound checker at time %0t", $time);
			abort_run();
		end else if (fifo_m2s_valid_o === 1'b1) begin
			if (exp_pops.size() == 0) begin
				$display("Valid pulse on the m2s port with no pop pending at time %0t", $time);
				abort_run();
			end else
				check_entry("fifo_m2s_dat_o/sel_o", exp_pops.pop_front(),
					m2s_entry_t'{data: fifo_m2s_dat_o, sel: fifo_m2s_sel_o});
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic we;
		adr_t adr;
		int   n;
		void'($urandom(32'he19c_97d6));
		reset_i        = 1'b1;
		wb_adr_i       = '0;
		wb_dat_i       = '0;
		wb_sel_i       = '0;
		wb_we_i        = 1'b0;
		wb_cyc_i       = 1'b0;
		wb_stb_i       = 1'b0;
		fifo_s2m_dat_i = '0;
		fifo_s2m_we_i  = 1'b0;
		fifo_m2s_re_i  = 1'b0;
		repeat (2) @(posedge wb_clk_i);
		#1;
		reset_i = 1'b0;

		check_flags();   // Idle state with irq low
		bus_read(adr_t'(`WBF_ADR_STATUS));

		repeat (5) bus_write(adr_t'(`WBF_ADR_DATA), $urandom, sel_t'($urandom));
		repeat (5) agent_cycle(1'b0, '0, 1'b1);

		repeat (4) agent_cycle(1'b1, $urandom, 1'b0);
		repeat (4) bus_read(adr_t'(`WBF_ADR_DATA));

		// Ninth word lost on m2s overflow and the last pop finds nothing
		repeat (9) bus_write(adr_t'(`WBF_ADR_DATA), $urandom, sel_t'($urandom));
		repeat (9) agent_cycle(1'b0, '0, 1'b1);

		// Three drops counted on s2m overflow
		repeat (11) agent_cycle(1'b1, $urandom, 1'b0);
		bus_read(adr_t'(`WBF_ADR_DROPS));
		bus_read(adr_t'(`WBF_ADR_STATUS));
		repeat (9) bus_read(adr_t'(`WBF_ADR_DATA));

		// Both directions at once
		for (int i = 0; i < 400; i++) begin
			we  = $urandom_range(0, 1);
			adr = ($urandom_range(0, 3) == 0) ? adr_t'($urandom_range(0, 7))
				: adr_t'(`WBF_ADR_DATA);
			if ($urandom_range(0, 3) == 0)
				agent_cycle($urandom_range(0, 1), $urandom, $urandom_range(0, 1));
			else
				bus_access(we, adr, $urandom, sel_t'($urandom), $urandom_range(0, 1), $urandom,
					$urandom_range(0, 1));
		end

		n = 0;
		while (exp_pops.size() != 0 && n < DRAIN_LIMIT) begin
			@(posedge wb_clk_i);
			n++;
		end
		if (exp_pops.size() != 0) begin
			$display("Timeout: %0d popped entries never reached the m2s port", exp_pops.size());
			abort_run();
		end else if (DUT.u_props.fail_cnt != 0) begin
			$display("%0d assertion failures in the bound checker", DUT.u_props.fail_cnt);
			abort_run();
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

/* sim/wbf_props.sv */
module wbf_props (
	input logic wb_clk_i,
	input logic reset_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_ack_o,
	input logic irq_o,
	input logic fifo_s2m_empty_o,
	input logic fifo_s2m_full_o,
	input logic fifo_m2s_re_i,
	input logic fifo_m2s_valid_o,
	input logic fifo_m2s_empty_o,
	input logic fifo_m2s_full_o
);

	int fail_cnt = 0;

	////////////////////////////////////////////////////////////
	// Bus handshake

	assert property (@(posedge wb_clk_i) disable iff (reset_i) wb_ack_o |=> !wb_ack_o)
	else begin
		$error("wb_ack_o high two cycles in a row");
		fail_cnt++;
	end

	assert property (@(posedge wb_clk_i) disable iff (reset_i)
		(wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
	else begin
		$error("bus request without ack one cycle later");
		fail_cnt++;
	end

	////////////////////////////////////////////////////////////
	// Outside port and flags

	assert property (@(posedge wb_clk_i) disable iff (reset_i)
		(fifo_m2s_re_i && !fifo_m2s_empty_o) |=> fifo_m2s_valid_o)
	else begin
		$error("m2s pop of a non-empty queue without valid");
		fail_cnt++;
	end

	assert property (@(posedge wb_clk_i) disable iff (reset_i) irq_o == !fifo_s2m_empty_o)
	else begin
		$error("irq_o does not track the s2m queue");
		fail_cnt++;
	end

	// Same queue cannot be empty and full
	assert property (@(posedge wb_clk_i) disable iff (reset_i)
		!(fifo_m2s_empty_o && fifo_m2s_full_o) && !(fifo_s2m_empty_o && fifo_s2m_full_o))
	else begin
		$error("queue flagged empty and full at once");
		fail_cnt++;
	end

endmodule

bind wbf_top wbf_props u_props (.*);

/* src/wbf_top.sv */
module wbf_top (
	input  logic            wb_clk_i,
	input  logic            reset_i,
	// Wishbone slave
	input  wbf_pkg::adr_t   wb_adr_i,
	input  wbf_pkg::word_t  wb_dat_i,
	input  wbf_pkg::sel_t   wb_sel_i,
	input  logic            wb_we_i,
	input  logic            wb_cyc_i,
	input  logic            wb_stb_i,
	output wbf_pkg::word_t  wb_dat_o,
	output logic            wb_ack_o,
	output logic            irq_o,
	// Outside agent
	input  wbf_pkg::word_t  fifo_s2m_dat_i,
	input  logic            fifo_s2m_we_i,
	output logic            fifo_s2m_empty_o,
	output logic            fifo_s2m_full_o,
	output wbf_pkg::word_t  fifo_m2s_dat_o,
	output wbf_pkg::sel_t   fifo_m2s_sel_o,
	output logic            fifo_m2s_valid_o,
	input  logic            fifo_m2s_re_i,
	output logic            fifo_m2s_empty_o,
	output logic            fifo_m2s_full_o
);

	import wbf_pkg::*;

	logic       m2s_push;
	logic       m2s_pop;
	m2s_entry_t m2s_entry;
	m2s_entry_t m2s_head;
	logic       s2m_push;
	logic       s2m_pop;
	word_t      s2m_data;
	word_t      s2m_head;
	drop_cnt_t  drop_cnt;

	////////////////////////////////////////////////////////////
	// Bus side

	wbf_regs u_regs (
		.wb_clk_i    (wb_clk_i),
		.reset_i     (reset_i),
		.wb_adr_i    (wb_adr_i),
		.wb_dat_i    (wb_dat_i),
		.wb_sel_i    (wb_sel_i),
		.wb_we_i     (wb_we_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.m2s_push_o  (m2s_push),
		.m2s_entry_o (m2s_entry),
		.m2s_full_i  (fifo_m2s_full_o),
		.m2s_empty_i (fifo_m2s_empty_o),
		.s2m_pop_o   (s2m_pop),
		.s2m_head_i  (s2m_head),
		.s2m_full_i  (fifo_s2m_full_o),
		.s2m_empty_i (fifo_s2m_empty_o),
		.drop_cnt_i  (drop_cnt),
		.irq_o       (irq_o)
	);

	////////////////////////////////////////////////////////////
	// Queues

	wbf_fifo #(.payload_t(m2s_entry_t)) u_m2s_fifo (   // Word with byte lanes
		.wb_clk_i    (wb_clk_i),
		.reset_i     (reset_i),
		.push_i      (m2s_push),
		.push_data_i (m2s_entry),
		.pop_i       (m2s_pop),
		.head_o      (m2s_head),
		.empty_o     (fifo_m2s_empty_o),
		.full_o      (fifo_m2s_full_o),
		.level_o     ()
	);

	wbf_fifo #(.payload_t(word_t)) u_s2m_fifo (
		.wb_clk_i    (wb_clk_i),
		.reset_i     (reset_i),
		.push_i      (s2m_push),
		.push_data_i (s2m_data),
		.pop_i       (s2m_pop),
		.head_o      (s2m_head),
		.empty_o     (fifo_s2m_empty_o),
		.full_o      (fifo_s2m_full_o),
		.level_o     ()
	);

	////////////////////////////////////////////////////////////
	// Outside side

	wbf_port u_port (
		.wb_clk_i         (wb_clk_i),
		.reset_i          (reset_i),
		.fifo_s2m_dat_i   (fifo_s2m_dat_i),
		.fifo_s2m_we_i    (fifo_s2m_we_i),
		.s2m_push_o       (s2m_push),
		.s2m_data_o       (s2m_data),
		.s2m_full_i       (fifo_s2m_full_o),
		.fifo_m2s_re_i    (fifo_m2s_re_i),
		.m2s_pop_o        (m2s_pop),
		.m2s_head_i       (m2s_head),
		.m2s_empty_i      (fifo_m2s_empty_o),
		.fifo_m2s_dat_o   (fifo_m2s_dat_o),
		.fifo_m2s_sel_o   (fifo_m2s_sel_o),
		.fifo_m2s_valid_o (fifo_m2s_valid_o),
		.drop_cnt_o       (drop_cnt)
	);

endmodule

/* src/wbf_port.sv */
module wbf_port (
	input  logic                 wb_clk_i,
	input  logic                 reset_i,
	input  wbf_pkg::word_t       fifo_s2m_dat_i,
	input  logic                 fifo_s2m_we_i,
	output logic                 s2m_push_o,
	output wbf_pkg::word_t       s2m_data_o,
	input  logic                 s2m_full_i,
	input  logic                 fifo_m2s_re_i,
	output logic                 m2s_pop_o,
	input  wbf_pkg::m2s_entry_t  m2s_head_i,
	input  logic                 m2s_empty_i,
	output wbf_pkg::word_t       fifo_m2s_dat_o,
	output wbf_pkg::sel_t        fifo_m2s_sel_o,
	output logic                 fifo_m2s_valid_o,
	output wbf_pkg::drop_cnt_t   drop_cnt_o
);

	import wbf_pkg::*;

	logic       drop;
	logic       valid_q;
	m2s_entry_t out_q;
	drop_cnt_t  drop_cnt_q;

	////////////////////////////////////////////////////////////
	// Outside push into s2m

	assign s2m_push_o = fifo_s2m_we_i & ~s2m_full_i;
	assign s2m_data_o = fifo_s2m_dat_i;
	assign drop       = fifo_s2m_we_i & s2m_full_i;   // Lost word

	always_ff @(posedge wb_clk_i) begin
		if (reset_i)
			drop_cnt_q <= '0;
		else if (drop && drop_cnt_q != '1)   // Stick at 255
			drop_cnt_q <= drop_cnt_q + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Outside pop from m2s

	assign m2s_pop_o = fifo_m2s_re_i & ~m2s_empty_i;

	always_ff @(posedge wb_clk_i) begin
		if (reset_i)
			valid_q <= 1'b0;
		else
			valid_q <= m2s_pop_o;   // One cycle per pop
	end

	always_ff @(posedge wb_clk_i) begin
		if (m2s_pop_o)
			out_q <= m2s_head_i;
	end

	assign fifo_m2s_dat_o   = out_q.data;
	assign fifo_m2s_sel_o   = out_q.sel;
	assign fifo_m2s_valid_o = valid_q;
	assign drop_cnt_o       = drop_cnt_q;

endmodule

/* src/wbf_regs.sv */
`include "wbf_cfg.svh"

module wbf_regs (
	input  logic                 wb_clk_i,
	input  logic                 reset_i,
	input  wbf_pkg::adr_t        wb_adr_i,
	input  wbf_pkg::word_t       wb_dat_i,
	input  wbf_pkg::sel_t        wb_sel_i,
	input  logic                 wb_we_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	output wbf_pkg::word_t       wb_dat_o,
	output logic                 wb_ack_o,
	output logic                 m2s_push_o,
	output wbf_pkg::m2s_entry_t  m2s_entry_o,
	input  logic                 m2s_full_i,
	input  logic                 m2s_empty_i,
	output logic                 s2m_pop_o,
	input  wbf_pkg::word_t       s2m_head_i,
	input  logic                 s2m_full_i,
	input  logic                 s2m_empty_i,
	input  wbf_pkg::drop_cnt_t   drop_cnt_i,
	output logic                 irq_o
);

	import wbf_pkg::*;

	logic    ack_q;
	logic    req;
	logic    hit_data;
	word_t   rd_data;
	word_t   dat_q;
	status_t status;

	////////////////////////////////////////////////////////////
	// Request decode

	// A held request is taken again only after the ack cycle
	assign req      = wb_cyc_i & wb_stb_i & ~ack_q;
	assign hit_data = (wb_adr_i == adr_t'(`WBF_ADR_DATA));

	// Full queue swallows the write, ack still goes out
	assign m2s_push_o  = req & wb_we_i & hit_data & ~m2s_full_i;
	assign m2s_entry_o = '{data: wb_dat_i, sel: wb_sel_i};

	assign s2m_pop_o = req & ~wb_we_i & hit_data & ~s2m_empty_i;

	////////////////////////////////////////////////////////////
	// Status and read mux

	assign irq_o  = ~s2m_empty_i;   // Level, follows the s2m queue
	assign status = '{
		irq:       irq_o,
		m2s_full:  m2s_full_i,
		m2s_empty: m2s_empty_i,
		s2m_full:  s2m_full_i,
		s2m_empty: s2m_empty_i
	};

	always_comb begin
		rd_data = '0;
		case (wb_adr_i)
			adr_t'(`WBF_ADR_DATA): begin
				if (!s2m_empty_i)
					rd_data = s2m_head_i;
			end
			adr_t'(`WBF_ADR_STATUS): rd_data = word_t'(status);
			adr_t'(`WBF_ADR_DROPS):  rd_data = word_t'(drop_cnt_i);
			default:                 rd_data = '0;   // Unused addresses read zero
		endcase
	end

	////////////////////////////////////////////////////////////
	// Ack pulse and read data

	always_ff @(posedge wb_clk_i) begin
		if (reset_i)
			ack_q <= 1'b0;
		else
			ack_q <= req;
	end

	// Captured with the pop, shown during ack
	always_ff @(posedge wb_clk_i) begin
		if (req)
			dat_q <= wb_we_i ? '0 : rd_data;
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = dat_q;

endmodule

/* src/wbf_fifo.sv */
`include "wbf_cfg.svh"

module wbf_fifo #(
	parameter type payload_t = wbf_pkg::word_t
) (
	input  logic            wb_clk_i,
	input  logic            reset_i,
	input  logic            push_i,
	input  payload_t        push_data_i,
	input  logic            pop_i,
	output payload_t        head_o,
	output logic            empty_o,
	output logic            full_o,
	output wbf_pkg::level_t level_o
);

	import wbf_pkg::*;

	localparam int PTR_W = $clog2(`WBF_DEPTH);

	payload_t         mem_q [`WBF_DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	level_t           level_q;

	////////////////////////////////////////////////////////////
	// Storage

	always_ff @(posedge wb_clk_i) begin
		if (push_i)
			mem_q[wr_ptr_q] <= push_data_i;
	end

	////////////////////////////////////////////////////////////
	// Pointers and level

	// Pointers wrap on their own since depth is a power of two
	always_ff @(posedge wb_clk_i) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_q  <= '0;
		end else begin
			if (push_i)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop_i)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({push_i, pop_i})
				2'b10:   level_q <= level_q + 1'b1;
				2'b01:   level_q <= level_q - 1'b1;
				default: level_q <= level_q;   // Push with pop keeps the level
			endcase
		end
	end

	// First word falls through
	assign head_o  = mem_q[rd_ptr_q];
	assign empty_o = (level_q == '0);
	assign full_o  = (level_q == level_t'(`WBF_DEPTH));
	assign level_o = level_q;

endmodule

/* src/wbf_pkg.sv */
`include "wbf_cfg.svh"

package wbf_pkg;

	typedef logic [`WBF_DW-1:0]   word_t;
	typedef logic [`WBF_SELW-1:0] sel_t;
	typedef logic [`WBF_AW-1:0]   adr_t;

	// Bus word plus its byte lanes
	typedef struct packed {
		word_t data;
		sel_t  sel;
	} m2s_entry_t;

	// Bit 0 is s2m_empty, bit 4 is irq
	typedef struct packed {
		logic irq;
		logic m2s_full;
		logic m2s_empty;
		logic s2m_full;
		logic s2m_empty;
	} status_t;

	typedef logic [7:0]                  drop_cnt_t;
	typedef logic [$clog2(`WBF_DEPTH):0] level_t;   // One extra bit to hold DEPTH

endpackage

/* src/wbf_cfg.svh */
`ifndef WBF_CFG_SVH
`define WBF_CFG_SVH

// Bus geometry
`define WBF_DW      32
`define WBF_AW      3
`define WBF_SELW    4

// Entries per queue, keep a power of two
`define WBF_DEPTH   8

// Register map
`define WBF_ADR_DATA    0
`define WBF_ADR_STATUS  1
`define WBF_ADR_DROPS   2

`endif
